// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dcache_tb
FLIST     := flist.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

# exit status of the simulation is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD)

// File: bench/dcache_properties.sv
`timescale 1ns/100ps

module dcache_properties import dcache_pkg::*; import mem_bus_pkg::*; (
  input logic         clock,
  input logic         reset,
  input mem_command_t mem_command,
  input addr_t        mem_addr,
  input logic         miss_valid,
  input logic         evict_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // memory bus

  // the cache never writes memory itself
  no_store_command: assert property (
    @(posedge clock) disable iff (reset) mem_command != bus_store
  ) else $error("memory store command issued by the cache");

  // loads are whole lines
  load_line_aligned: assert property (
    @(posedge clock) disable iff (reset)
      (mem_command == bus_load) |-> (mem_addr.offset == '0)
  ) else $error("memory load address %h is not line aligned", mem_addr);

  ////////////////////////////////////////////////////////////////////////////
  // outputs right after reset
  quiet_after_reset: assert property (
    @(posedge clock) $fell(reset) |-> (!miss_valid && !evict_valid)
  ) else $error("miss or eviction output active right after reset");

endmodule

// File: bench/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb import dcache_pkg::*; import mem_bus_pkg::*; ();

  typedef enum logic [1:0] {op_read, op_store, op_burst} op_t;

  // burst rows read count lines, data[15:0] is the address step
  typedef struct packed {
    op_t         op;
    logic [15:0] addr;
    logic [63:0] data;
    logic        hit;
    logic [2:0]  count;
  } row_t;

  typedef logic [addr_width-offset_bits-1:0] line_t;

  localparam int num_rows    = 16;
  localparam int num_lines   = 1 << (addr_width - offset_bits);
  localparam int cycle_limit = num_rows * 40 + 5;

  logic                    clock;
  logic                    reset;
  logic                    rd_en;
  addr_t                   rd_addr;
  logic                    wr_en;
  addr_t                   wr_addr;
  logic [data_width-1:0]   wr_data;
  logic [data_width-1:0]   rd_data;
  logic                    rd_valid;
  logic                    miss_valid;
  addr_t                   miss_addr;
  logic [data_width-1:0]   miss_data;
  mem_command_t            mem_command;
  addr_t                   mem_addr;
  logic [mem_tag_bits-1:0] mem_response;
  logic [data_width-1:0]   mem_data;
  logic [mem_tag_bits-1:0] mem_data_tag;
  logic                    evict_valid;
  evict_t                  evict_line;

  logic [63:0] mem_words [num_lines];
  logic [63:0] golden [num_lines];
  int          returned [num_lines];
  int          evict_count;
  logic [3:0]  pend_tag [$];
  line_t       pend_line [$];
  int          pend_due [$];

  row_t stim_rows [num_rows] = '{
    '{op_read,  16'h00c0, 64'h0,                   1'b0, 3'd1},
    '{op_read,  16'h0090, 64'h0,                   1'b0, 3'd1},
    '{op_store, 16'h0090, 64'h1111_2222_3333_4444, 1'b0, 3'd1},
    '{op_read,  16'h0090, 64'h0,                   1'b1, 3'd1},
    '{op_store, 16'h00d0, 64'h5555_6666_7777_8888, 1'b0, 3'd1},
    '{op_read,  16'h00d4, 64'h0,                   1'b1, 3'd1},
    // set 5 gets one dirty line, then four more lines
    '{op_store, 16'h0068, 64'h0f1e_2d3c_4b5a_6978, 1'b0, 3'd1},
    '{op_read,  16'h00a8, 64'h0,                   1'b0, 3'd1},
    '{op_read,  16'h00e8, 64'h0,                   1'b0, 3'd1},
    '{op_read,  16'h0128, 64'h0,                   1'b0, 3'd1},
    '{op_read,  16'h016c, 64'h0,                   1'b0, 3'd1},
    '{op_read,  16'h006a, 64'h0,                   1'b0, 3'd1},
    '{op_burst, 16'h1008, 64'h1010,                1'b0, 3'd4},
    '{op_burst, 16'h8004, 64'h0808,                1'b0, 3'd4},
    // same line twice
    '{op_burst, 16'h5010, 64'h0,                   1'b0, 3'd2},
    '{op_read,  16'h5010, 64'h0,                   1'b1, 3'd1}
  };

  dcache_top u_dcache_top (
    .clock        (clock),
    .reset        (reset),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .miss_valid   (miss_valid),
    .miss_addr    (miss_addr),
    .miss_data    (miss_data),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_data_tag (mem_data_tag),
    .evict_valid  (evict_valid),
    .evict_line   (evict_line)
  );

  bind dcache_top dcache_properties u_dcache_properties (
    .clock       (clock),
    .reset       (reset),
    .mem_command (mem_command),
    .mem_addr    (mem_addr),
    .miss_valid  (miss_valid),
    .evict_valid (evict_valid)
  );

  initial clock = 1'b0;
  always #10 clock = ~clock;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  function automatic line_t line_of(input logic [15:0] addr);
    return addr[15:3];
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // processor side
  task automatic read_line(input logic [15:0] addr, output logic hit,
                           output logic [63:0] data);
    rd_en   = 1'b1;
    rd_addr = addr;
    @(negedge clock);
    hit  = rd_valid;
    data = rd_data;
    @(posedge clock);
    #2;
    rd_en = 1'b0;
  endtask

  task automatic store_line(input logic [15:0] addr, input logic [63:0] data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    golden[line_of(addr)] = data;
    @(posedge clock);
    #2;
    wr_en = 1'b0;
  endtask

  // returns inside the miss_valid cycle of that line
  task automatic wait_return(input line_t line, input int base);
    do begin
      @(posedge clock);
      #2;
    end while (returned[line] == base &&
               !(miss_valid && line_of(miss_addr) == line));
  endtask

  task automatic read_expect_hit(input logic [15:0] addr, input string name);
    logic        hit;
    logic [63:0] data;
    read_line(addr, hit, data);
    check({name, " hit"}, 64'd1, 64'(hit));
    check({name, " data"}, golden[line_of(addr)], data);
  endtask

  task automatic apply_row(input row_t row, input int r);
    logic        hit;
    logic [63:0] data;
    logic [15:0] addrs [4];
    int          base [4];
    string       name;
    name = $sformatf("row %0d", r);
    if (row.op == op_store) begin
      store_line(row.addr, row.data);
    end else if (row.op == op_read) begin
      base[0] = returned[line_of(row.addr)];
      read_line(row.addr, hit, data);
      check({name, " read hit"}, 64'(row.hit), 64'(hit));
      if (hit) begin
        check({name, " read data"}, golden[line_of(row.addr)], data);
      end else begin
        wait_return(line_of(row.addr), base[0]);
        read_expect_hit(row.addr, {name, " repeated read"});
      end
    end else begin
      // back to back reads, all expected to miss
      for (int k = 0; k < int'(row.count); k++) begin
        addrs[k] = row.addr + 16'(k) * row.data[15:0];
        base[k]  = returned[line_of(addrs[k])];
        read_line(addrs[k], hit, data);
        check($sformatf("%s burst read %0d hit", name, k), 64'd0, 64'(hit));
      end
      for (int k = 0; k < int'(row.count); k++) begin
        wait_return(line_of(addrs[k]), base[k]);
      end
      // late duplicates would show up here
      repeat (6) @(posedge clock);
      #2;
      for (int k = 0; k < int'(row.count); k++) begin
        check($sformatf("%s burst line %0d returns", name, k), 64'd1,
              64'(returned[line_of(addrs[k])] - base[k]));
      end
      for (int k = 0; k < int'(row.count); k++) begin
        read_expect_hit(addrs[k], $sformatf("%s burst reread %0d", name, k));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  initial begin : memory_model
    logic [31:0] lfsr;
    logic [63:0] word;
    logic [3:0]  next_tag;
    int          mem_cycle;
    line_t       line;
    mem_response = '0;
    mem_data     = '0;
    mem_data_tag = '0;
    lfsr         = 32'h56509fcb;
    next_tag     = 4'd1;
    mem_cycle    = 0;
    for (int i = 0; i < num_lines; i++) begin
      word = '0;
      for (int b = 0; b < 64; b++) begin
        lfsr = lfsr_next(lfsr);
        word = {word[62:0], lfsr[0]};
      end
      mem_words[i] = word;
    end
    forever begin
      @(posedge clock);
      #2;
      mem_cycle++;
      mem_response = '0;
      mem_data_tag = '0;
      if (evict_valid) begin
        mem_words[{evict_line.tag, evict_line.index}] = evict_line.data;
      end
      if (mem_command == bus_load) begin
        lfsr = lfsr_next(lfsr);
        // low bit set means busy
        if (!lfsr[0]) begin
          mem_response = next_tag;
          pend_tag.push_back(next_tag);
          pend_line.push_back(line_of(mem_addr));
          pend_due.push_back(mem_cycle + 5);
          next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
      end
      if (pend_due.size() > 0 && pend_due[0] <= mem_cycle) begin
        line         = pend_line.pop_front();
        mem_data_tag = pend_tag.pop_front();
        void'(pend_due.pop_front());
        mem_data     = mem_words[line];
      end
    end
  end

  // miss returns and evictions
  always @(negedge clock) begin
    if (!reset && miss_valid) begin
      returned[line_of(miss_addr)]++;
      check("miss return offset", 64'd0, 64'(miss_addr.offset));
      check($sformatf("miss return %h", miss_addr), golden[line_of(miss_addr)],
            miss_data);
    end
    if (!reset && evict_valid) begin
      evict_count++;
      check($sformatf("eviction %h", {evict_line.tag, evict_line.index}),
            golden[{evict_line.tag, evict_line.index}], evict_line.data);
    end
  end

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("TEST FAILED");
    $fatal(1, "timeout, no result after %0d clock cycles", cycle_limit);
  end

  initial begin : stimulus
    rd_en   = 1'b0;
    rd_addr = '0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    reset   = 1'b1;
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    for (int i = 0; i < num_lines; i++) begin
      golden[i] = mem_words[i];
    end
    for (int r = 0; r < num_rows; r++) begin
      apply_row(stim_rows[r], r);
    end
    // only the dirty line of set 5 gets displaced
    check("eviction count", 64'd1, 64'(evict_count));
    $display("TEST OK");
    $finish;
  end

endmodule

// File: flist.f
src/dcache_pkg.sv
src/mem_bus_pkg.sv
src/plru_tree.sv
src/cache_array.sv
src/miss_queue.sv
src/dcache_top.sv
bench/dcache_properties.sv
bench/dcache_tb.sv

// File: src/cache_array.sv
`timescale 1ns/100ps

module cache_array import dcache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  rd_en,
  input  addr_t                 rd_addr,
  input  logic                  wr_en,
  input  addr_t                 wr_addr,
  input  logic [data_width-1:0] wr_data,
  input  logic                  fill_valid,
  input  cache_line_t           fill_line,
  input  logic [set_bits-1:0]   fill_set,
  output logic [data_width-1:0] rd_data,
  output logic                  rd_valid,
  output logic                  read_miss,
  output addr_t                 read_miss_addr,
  output logic                  evict_valid,
  output evict_t                evict_line
);

  cache_line_t lines [num_sets][num_ways];

  logic [num_ways-1:0] rd_hit_vec;
  logic [1:0]          rd_hit_way;
  logic                rd_hit;
  logic                rd_fill_hit;

  logic [num_ways-1:0] st_hit_vec;
  logic [num_ways-1:0] st_free_vec;
  logic [1:0]          st_victim;
  logic [1:0]          st_way;
  logic                st_hit;
  logic                st_evict;
  cache_line_t         st_old;

  logic [num_ways-1:0] fl_present_vec;
  logic [num_ways-1:0] fl_free_vec;
  logic [1:0]          fl_victim;
  logic [1:0]          fl_way;
  logic                same_set;
  logic                fl_present;
  logic                fl_evict;
  logic                fl_write;
  cache_line_t         fl_old;

  // lowest way set in a mask
  function automatic logic [1:0] first_way(input logic [num_ways-1:0] mask);
    logic [1:0] way;
    way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (mask[w]) begin
        way = 2'(w);
      end
    end
    return way;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // read lookup
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      rd_hit_vec[w] = lines[rd_addr.index][w].valid &&
                      (lines[rd_addr.index][w].tag == rd_addr.tag);
    end
  end

  // line being filled this cycle counts as present
  assign rd_fill_hit    = fl_write && (fill_set == rd_addr.index) &&
                          (fill_line.tag == rd_addr.tag);
  assign rd_hit         = (|rd_hit_vec) || rd_fill_hit;
  assign rd_hit_way     = rd_fill_hit ? fl_way : first_way(rd_hit_vec);
  assign rd_data        = rd_fill_hit ? fill_line.data :
                                        lines[rd_addr.index][rd_hit_way].data;
  assign rd_valid       = rd_en && rd_hit;
  assign read_miss      = rd_en && !rd_hit;
  assign read_miss_addr = rd_addr;

  ////////////////////////////////////////////////////////////////////////////
  // store placement, hit way first, then an empty way, then the victim
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      st_hit_vec[w]  = lines[wr_addr.index][w].valid &&
                       (lines[wr_addr.index][w].tag == wr_addr.tag);
      st_free_vec[w] = !lines[wr_addr.index][w].valid;
    end
  end

  assign st_hit   = |st_hit_vec;
  assign st_way   = st_hit          ? first_way(st_hit_vec)  :
                    (|st_free_vec)  ? first_way(st_free_vec) : st_victim;
  assign st_old   = lines[wr_addr.index][st_way];
  assign st_evict = wr_en && !st_hit && st_old.valid && st_old.dirty;

  ////////////////////////////////////////////////////////////////////////////
  // fill placement, sees the set as the store in this cycle leaves it
  assign same_set = wr_en && (wr_addr.index == fill_set);

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      fl_present_vec[w] = lines[fill_set][w].valid &&
                          (lines[fill_set][w].tag == fill_line.tag);
      fl_free_vec[w]    = !lines[fill_set][w].valid &&
                          !(same_set && (st_way == 2'(w)));
    end
  end

  assign fl_present = (|fl_present_vec) || (same_set && (wr_addr.tag == fill_line.tag));

  // a store in the same set moves the tree root to the other half
  always_comb begin
    if (|fl_free_vec) begin
      fl_way = first_way(fl_free_vec);
    end else if (same_set && (fl_victim == st_way)) begin
      fl_way = {~st_way[1], fl_victim[0]};
    end else begin
      fl_way = fl_victim;
    end
  end

  assign fl_old   = lines[fill_set][fl_way];
  assign fl_evict = !(|fl_free_vec) && fl_old.valid && fl_old.dirty;
  // second dirty victim in one cycle, fill not kept and line refetched later
  assign fl_write = fill_valid && !fl_present && !(fl_evict && st_evict);

  plru_tree u_write_lru (
    .clock      (clock),
    .reset      (reset),
    .touch_en   (wr_en || fl_write),
    .touch_set  (wr_en ? wr_addr.index : fill_set),
    .touch_way  (wr_en ? st_way : fl_way),
    .lookup_set (wr_addr.index),
    .victim_way (st_victim)
  );

  plru_tree u_read_lru (
    .clock      (clock),
    .reset      (reset),
    .touch_en   (rd_valid || fl_write),
    .touch_set  (rd_valid ? rd_addr.index : fill_set),
    .touch_way  (rd_valid ? rd_hit_way : fl_way),
    .lookup_set (fill_set),
    .victim_way (fl_victim)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        for (int w = 0; w < num_ways; w++) begin
          lines[s][w].valid <= 1'b0;
          lines[s][w].dirty <= 1'b0;
        end
      end
      evict_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        lines[wr_addr.index][st_way] <= '{data: wr_data, tag: wr_addr.tag,
                                          valid: 1'b1, dirty: 1'b1};
      end
      if (fl_write) begin
        lines[fill_set][fl_way] <= fill_line;
      end
      evict_valid <= st_evict || (fl_write && fl_evict);
    end
  end

  always_ff @(posedge clock) begin
    if (st_evict) begin
      evict_line <= '{tag: st_old.tag, index: wr_addr.index, data: st_old.data};
    end else begin
      evict_line <= '{tag: fl_old.tag, index: fill_set, data: fl_old.data};
    end
  end

endmodule

// File: src/dcache_pkg.sv
package dcache_pkg;

  // cache geometry
  localparam int addr_width  = 16;
  localparam int data_width  = 64;
  localparam int offset_bits = 3;
  localparam int num_ways    = 4;
  localparam int num_sets    = 8;
  localparam int set_bits    = 3;
  localparam int tag_bits    = addr_width - set_bits - offset_bits;
  localparam int lru_bits    = num_ways - 1;

  // byte address split into its fields
  typedef struct packed {
    logic [tag_bits-1:0]    tag;
    logic [set_bits-1:0]    index;
    logic [offset_bits-1:0] offset;
  } addr_t;

  // one way of one set
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [tag_bits-1:0]   tag;
    logic                  valid;
    logic                  dirty;
  } cache_line_t;

  // displaced dirty line, line address and contents
  typedef struct packed {
    logic [tag_bits-1:0]   tag;
    logic [set_bits-1:0]   index;
    logic [data_width-1:0] data;
  } evict_t;

endpackage

// File: src/dcache_top.sv
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*; import mem_bus_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  // processor
  input  logic                    rd_en,
  input  addr_t                   rd_addr,
  input  logic                    wr_en,
  input  addr_t                   wr_addr,
  input  logic [data_width-1:0]   wr_data,
  output logic [data_width-1:0]   rd_data,
  output logic                    rd_valid,
  output logic                    miss_valid,
  output addr_t                   miss_addr,
  output logic [data_width-1:0]   miss_data,
  // memory
  output mem_command_t            mem_command,
  output addr_t                   mem_addr,
  input  logic [mem_tag_bits-1:0] mem_response,
  input  logic [data_width-1:0]   mem_data,
  input  logic [mem_tag_bits-1:0] mem_data_tag,
  // displaced dirty lines
  output logic                    evict_valid,
  output evict_t                  evict_line
);

  logic                read_miss;
  addr_t               read_miss_addr;
  logic                fill_valid;
  cache_line_t         fill_line;
  logic [set_bits-1:0] fill_set;

  cache_array u_cache_array (
    .clock          (clock),
    .reset          (reset),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .fill_valid     (fill_valid),
    .fill_line      (fill_line),
    .fill_set       (fill_set),
    .rd_data        (rd_data),
    .rd_valid       (rd_valid),
    .read_miss      (read_miss),
    .read_miss_addr (read_miss_addr),
    .evict_valid    (evict_valid),
    .evict_line     (evict_line)
  );

  miss_queue u_miss_queue (
    .clock          (clock),
    .reset          (reset),
    .read_miss      (read_miss),
    .read_miss_addr (read_miss_addr),
    .mem_response   (mem_response),
    .mem_data       (mem_data),
    .mem_data_tag   (mem_data_tag),
    .mem_command    (mem_command),
    .mem_addr       (mem_addr),
    .fill_valid     (fill_valid),
    .fill_line      (fill_line),
    .fill_set       (fill_set),
    .miss_valid     (miss_valid),
    .miss_addr      (miss_addr),
    .miss_data      (miss_data)
  );

endmodule

// File: src/mem_bus_pkg.sv
package mem_bus_pkg;

  import dcache_pkg::*;

  // memory transaction tags, zero means no tag
  localparam int mem_tag_bits = 4;
  localparam int miss_depth   = 4;

  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } mem_command_t;

  // life of a miss queue slot
  typedef enum logic [1:0] {
    entry_free = 2'd0,
    entry_send = 2'd1,
    entry_wait = 2'd2
  } miss_state_t;

  typedef struct packed {
    logic [tag_bits-1:0]     line_tag;
    logic [set_bits-1:0]     line_index;
    logic [mem_tag_bits-1:0] mem_tag;
    miss_state_t             state;
  } miss_entry_t;

endpackage

// File: src/miss_queue.sv
`timescale 1ns/100ps

module miss_queue import dcache_pkg::*; import mem_bus_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    read_miss,
  input  addr_t                   read_miss_addr,
  input  logic [mem_tag_bits-1:0] mem_response,
  input  logic [data_width-1:0]   mem_data,
  input  logic [mem_tag_bits-1:0] mem_data_tag,
  output mem_command_t            mem_command,
  output addr_t                   mem_addr,
  output logic                    fill_valid,
  output cache_line_t             fill_line,
  output logic [set_bits-1:0]     fill_set,
  output logic                    miss_valid,
  output addr_t                   miss_addr,
  output logic [data_width-1:0]   miss_data
);

  miss_entry_t entry [miss_depth];
  // older[i][j] set when slot i was enqueued before slot j
  logic [miss_depth-1:0] older [miss_depth];

  logic [miss_depth-1:0]         free_vec;
  logic [miss_depth-1:0]         send_vec;
  logic [miss_depth-1:0]         dup_vec;
  logic [miss_depth-1:0]         oldest_vec;
  logic [miss_depth-1:0]         match_vec;
  logic [$clog2(miss_depth)-1:0] alloc_slot;
  logic [$clog2(miss_depth)-1:0] issue_slot;
  logic [$clog2(miss_depth)-1:0] match_slot;
  logic                          enqueue;
  logic                          issuing;
  logic                          accepted;
  logic                          matched;

  function automatic logic [$clog2(miss_depth)-1:0] first_slot(
    input logic [miss_depth-1:0] mask
  );
    logic [$clog2(miss_depth)-1:0] slot;
    slot = '0;
    for (int i = miss_depth - 1; i >= 0; i--) begin
      if (mask[i]) begin
        slot = $clog2(miss_depth)'(i);
      end
    end
    return slot;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // slot search
  always_comb begin
    for (int i = 0; i < miss_depth; i++) begin
      free_vec[i]  = (entry[i].state == entry_free);
      send_vec[i]  = (entry[i].state == entry_send);
      // slot matched this cycle still counts, its line is not written yet
      dup_vec[i]   = (entry[i].state != entry_free) &&
                     (entry[i].line_tag == read_miss_addr.tag) &&
                     (entry[i].line_index == read_miss_addr.index);
      match_vec[i] = (entry[i].state == entry_wait) &&
                     (entry[i].mem_tag == mem_data_tag);
    end
    for (int i = 0; i < miss_depth; i++) begin
      oldest_vec[i] = send_vec[i];
      for (int j = 0; j < miss_depth; j++) begin
        if (send_vec[j] && older[j][i]) begin
          oldest_vec[i] = 1'b0;
        end
      end
    end
  end

  assign enqueue    = read_miss && !(|dup_vec) && (|free_vec);
  assign alloc_slot = first_slot(free_vec);
  assign issuing    = |send_vec;
  assign issue_slot = first_slot(oldest_vec);
  assign accepted   = issuing && (mem_response != '0);
  assign matched    = (mem_data_tag != '0) && (|match_vec);
  assign match_slot = first_slot(match_vec);

  ////////////////////////////////////////////////////////////////////////////
  // memory command, held until memory answers with a tag
  assign mem_command = issuing ? bus_load : bus_none;
  assign mem_addr    = issuing ? '{tag: entry[issue_slot].line_tag,
                                   index: entry[issue_slot].line_index,
                                   offset: '0} : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < miss_depth; i++) begin
        entry[i] <= '0;
        older[i] <= '0;
      end
      fill_valid <= 1'b0;
    end else begin
      if (enqueue) begin
        entry[alloc_slot] <= '{line_tag: read_miss_addr.tag,
                               line_index: read_miss_addr.index,
                               mem_tag: '0, state: entry_send};
        for (int j = 0; j < miss_depth; j++) begin
          older[alloc_slot][j] <= 1'b0;
          if (j != int'(alloc_slot)) begin
            older[j][alloc_slot] <= 1'b1;
          end
        end
      end
      if (accepted) begin
        entry[issue_slot].mem_tag <= mem_response;
        entry[issue_slot].state   <= entry_wait;
      end
      if (matched) begin
        entry[match_slot].state <= entry_free;
      end
      fill_valid <= matched;
    end
  end

  // returned line, goes to the array and the processor together
  always_ff @(posedge clock) begin
    if (matched) begin
      fill_line <= '{data: mem_data, tag: entry[match_slot].line_tag,
                     valid: 1'b1, dirty: 1'b0};
      fill_set  <= entry[match_slot].line_index;
    end
  end

  assign miss_valid = fill_valid;
  assign miss_data  = fill_line.data;
  assign miss_addr  = '{tag: fill_line.tag, index: fill_set, offset: '0};

endmodule

// File: src/plru_tree.sv
`timescale 1ns/100ps

module plru_tree import dcache_pkg::*; (
  input  logic                clock,
  input  logic                reset,
  input  logic                touch_en,
  input  logic [set_bits-1:0] touch_set,
  input  logic [1:0]          touch_way,
  input  logic [set_bits-1:0] lookup_set,
  output logic [1:0]          victim_way
);

  // bit 0 points at the older half
  // bit 1 covers ways 0 and 1, bit 2 covers ways 2 and 3
  logic [lru_bits-1:0] tree [num_sets];
  logic [lru_bits-1:0] lookup_tree;

  assign lookup_tree = tree[lookup_set];

  always_comb begin
    victim_way[1] = lookup_tree[0];
    victim_way[0] = lookup_tree[0] ? lookup_tree[2] : lookup_tree[1];
  end

  // point every bit on the path away from the touched way
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        tree[s] <= '0;
      end
    end else if (touch_en) begin
      tree[touch_set][0] <= ~touch_way[1];
      if (touch_way[1]) begin
        tree[touch_set][2] <= ~touch_way[0];
      end else begin
        tree[touch_set][1] <= ~touch_way[0];
      end
    end
  end

endmodule
